// ==== hdl/chip_settings.svh ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Chip loader settings: RAM size, reserved
// software addresses, UART bit time, SPI opcodes
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef CHIP_SETTINGS_SVH
`define CHIP_SETTINGS_SVH

// Word address width for 1024 words
`define RAM_AW 10

// Reserved words snooped by the status monitor
`define STATUS_ADDR 10'h3F0
`define LOG_ADDR 10'h3F1

`define UART_CLKS_PER_BIT 16

// SPI opcode bytes
`define OP_WRITE 8'h02
`define OP_READ 8'h03

`endif

// ==== hdl/chip_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types: RAM request struct and the
// software test-status codes
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package chip_pkg;

`include "chip_settings.svh"

  // One RAM access as issued by a loader
  typedef struct packed {
    logic               write;
    logic [`RAM_AW-1:0] addr;
    logic [31:0]        wdata;
  } mem_req_t;

  // Values software writes to the test-status word
  typedef enum logic [31:0] {
    StatusInTest = 32'h0000_4354,
    StatusPassed = 32'h0000_900D,
    StatusFailed = 32'h0000_BAAD
  } status_e;

endpackage

// ==== hdl/spi_loader.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SPI device loader: write and read frames to
// RAM requests, read data shifted out on miso
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

`include "chip_settings.svh"

module spi_loader (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               sck_i,
  input  logic               csb_i,
  input  logic               mosi_i,
  output logic               miso_o,
  output logic               req_o,
  output chip_pkg::mem_req_t mem_req_o,
  input  logic               gnt_i,
  input  logic [31:0]        rdata_i,
  input  logic               rdata_valid_i
);

  logic [2:0]         sck_q;
  logic [1:0]         csb_q;
  logic [1:0]         mosi_q;
  logic               sck_rise;
  logic               sck_fall;
  logic               csb;
  logic [5:0]         bit_cnt_q;
  logic               hold_q;
  logic               frame_end;
  logic               accept;
  logic               issue_rd;
  logic               issue_wr;
  logic [31:0]        shift_q;
  logic [31:0]        shift_next;
  logic [7:0]         op_q;
  logic [`RAM_AW-1:0] addr_q;
  logic               req_q;
  chip_pkg::mem_req_t mem_req_q;
  logic [31:0]        rd_word_q;
  logic [5:0]         miso_idx;
  logic               miso_q;

  // Pin synchronizers with a third sck stage for edge detect
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sck_q  <= '0;
      csb_q  <= 2'b11;
      mosi_q <= '0;
    end else begin
      sck_q  <= {sck_q[1:0], sck_i};
      csb_q  <= {csb_q[0], csb_i};
      mosi_q <= {mosi_q[0], mosi_i};
    end
  end

  assign sck_rise   = sck_q[1] & ~sck_q[2];
  assign sck_fall   = ~sck_q[1] & sck_q[2];
  assign csb        = csb_q[1];
  assign shift_next = {shift_q[30:0], mosi_q[1]};
  assign frame_end  = (bit_cnt_q == 6'd56);
  assign accept     = sck_rise & ~csb & ~req_q & ~hold_q & ~frame_end;
  // Read goes out as soon as the last address bit is in
  assign issue_rd   = accept && (bit_cnt_q == 6'd23) && (op_q == `OP_READ);
  assign issue_wr   = accept && (bit_cnt_q == 6'd55) && (op_q == `OP_WRITE);
  assign miso_idx   = 6'd55 - bit_cnt_q;

  // Bit counter that stops while a busy loader sits out the frame
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      bit_cnt_q <= '0;
      hold_q    <= 1'b0;
    end else if (csb) begin
      bit_cnt_q <= '0;
      hold_q    <= 1'b0;
    end else if (sck_rise) begin
      if (req_q || hold_q || frame_end) begin
        hold_q <= 1'b1;
      end else begin
        bit_cnt_q <= bit_cnt_q + 6'd1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      shift_q <= shift_next;
      if (bit_cnt_q == 6'd7) begin
        op_q <= shift_next[7:0];
      end
      if (bit_cnt_q == 6'd23) begin
        addr_q <= shift_next[`RAM_AW-1:0];
      end
    end
    if (issue_rd) begin
      mem_req_q <= '{write: 1'b0, addr: shift_next[`RAM_AW-1:0], wdata: '0};
    end else if (issue_wr) begin
      mem_req_q <= '{write: 1'b1, addr: addr_q, wdata: shift_next};
    end
    // Only this loader reads, so any read data is ours
    if (rdata_valid_i) begin
      rd_word_q <= rdata_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      req_q <= 1'b0;
    end else if (gnt_i) begin
      req_q <= 1'b0;
    end else if (issue_rd || issue_wr) begin
      req_q <= 1'b1;
    end
  end

  // First data bit loads straight from the RAM, in case the
  // falling edge for it has already gone by
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      miso_q <= 1'b0;
    end else if (csb) begin
      miso_q <= 1'b0;
    end else if (rdata_valid_i) begin
      miso_q <= rdata_i[31];
    end else if (sck_fall && (op_q == `OP_READ) &&
                 (bit_cnt_q >= 6'd24) && (bit_cnt_q <= 6'd55)) begin
      miso_q <= rd_word_q[miso_idx[4:0]];
    end
  end

  assign miso_o    = miso_q;
  assign req_o     = req_q;
  assign mem_req_o = mem_req_q;

endmodule

// ==== hdl/uart_loader.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UART 8N1 loader: six-byte write frames turned
// into RAM write requests
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

`include "chip_settings.svh"

module uart_loader (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               rx_i,
  output logic               req_o,
  output chip_pkg::mem_req_t mem_req_o,
  input  logic               gnt_i
);

  localparam int CntW = $clog2(`UART_CLKS_PER_BIT);

  typedef enum logic [1:0] {RxIdle, RxStart, RxData, RxStop} rx_state_e;

  logic [1:0]         rx_q;
  logic               rx;
  rx_state_e          state_q;
  logic [CntW-1:0]    clk_cnt_q;
  logic [2:0]         bit_idx_q;
  logic               half_bit;
  logic               full_bit;
  logic               byte_done;
  logic [7:0]         byte_q;
  logic [2:0]         byte_cnt_q;
  logic [39:0]        frame_q;
  logic               req_q;
  chip_pkg::mem_req_t mem_req_q;

  assign rx       = rx_q[1];
  assign half_bit = (clk_cnt_q == CntW'(`UART_CLKS_PER_BIT / 2 - 1));
  assign full_bit = (clk_cnt_q == CntW'(`UART_CLKS_PER_BIT - 1));
  // Good stop bit and no write pending
  assign byte_done = (state_q == RxStop) && full_bit && rx && !req_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rx_q      <= 2'b11;
      state_q   <= RxIdle;
      clk_cnt_q <= '0;
      bit_idx_q <= '0;
    end else begin
      rx_q <= {rx_q[0], rx_i};
      case (state_q)
        RxIdle: begin
          clk_cnt_q <= '0;
          if (!rx) begin
            state_q <= RxStart;
          end
        end
        // Mid start bit check rejects short glitches
        RxStart: begin
          if (half_bit) begin
            clk_cnt_q <= '0;
            bit_idx_q <= '0;
            state_q   <= rx ? RxIdle : RxData;
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        RxData: begin
          if (full_bit) begin
            clk_cnt_q <= '0;
            bit_idx_q <= bit_idx_q + 3'd1;
            if (bit_idx_q == 3'd7) begin
              state_q <= RxStop;
            end
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        RxStop: begin
          if (full_bit) begin
            state_q <= RxIdle;
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        default: state_q <= RxIdle;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      byte_cnt_q <= '0;
      req_q      <= 1'b0;
    end else begin
      if (gnt_i) begin
        req_q <= 1'b0;
      end
      if (byte_done) begin
        if (byte_cnt_q == 3'd5) begin
          byte_cnt_q <= '0;
          req_q      <= 1'b1;
        end else begin
          byte_cnt_q <= byte_cnt_q + 3'd1;
        end
      end
    end
  end

  // Bits arrive LSB first and bytes stack up high byte first
  always_ff @(posedge clk_i) begin
    if ((state_q == RxData) && full_bit) begin
      byte_q <= {rx, byte_q[7:1]};
    end
    if (byte_done) begin
      frame_q <= {frame_q[31:0], byte_q};
      if (byte_cnt_q == 3'd5) begin
        mem_req_q <= '{write: 1'b1,
                       addr:  frame_q[24 +: `RAM_AW],
                       wdata: {frame_q[23:0], byte_q}};
      end
    end
  end

  assign req_o     = req_q;
  assign mem_req_o = mem_req_q;

endmodule

// ==== hdl/ram_arbiter.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Round-robin arbiter of two loaders onto one RAM
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module ram_arbiter (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic [1:0]               req_i,
  input  chip_pkg::mem_req_t [1:0] mem_req_i,
  output logic [1:0]               gnt_o,
  output logic                     ram_valid_o,
  output chip_pkg::mem_req_t       ram_req_o
);

  logic [1:0]         req_eff;
  logic [1:0]         pick;
  logic               last_q;
  logic [1:0]         gnt_q;
  logic               ram_valid_q;
  chip_pkg::mem_req_t ram_req_q;

  // A requester still holds req in its grant cycle
  assign req_eff = req_i & ~gnt_q;

  always_comb begin
    if (&req_eff) begin
      pick = last_q ? 2'b01 : 2'b10;
    end else begin
      pick = req_eff;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      last_q      <= 1'b0;
      gnt_q       <= '0;
      ram_valid_q <= 1'b0;
    end else begin
      gnt_q       <= pick;
      ram_valid_q <= |pick;
      if (|pick) begin
        last_q <= pick[1];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    ram_req_q <= pick[1] ? mem_req_i[1] : mem_req_i[0];
  end

  assign gnt_o       = gnt_q;
  assign ram_valid_o = ram_valid_q;
  assign ram_req_o   = ram_req_q;

endmodule

// ==== hdl/main_ram.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Single-port main RAM with a one-cycle read
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

`include "chip_settings.svh"

module main_ram (
  input  logic               clk_i,
  input  logic               ram_valid_i,
  input  chip_pkg::mem_req_t ram_req_i,
  output logic [31:0]        rdata_o,
  output logic               rdata_valid_o
);

  logic [31:0] mem_q [2**`RAM_AW];
  logic [31:0] rdata_q;
  logic        rdata_valid_q;

  always_ff @(posedge clk_i) begin
    rdata_valid_q <= ram_valid_i && !ram_req_i.write;
    if (ram_valid_i) begin
      if (ram_req_i.write) begin
        mem_q[ram_req_i.addr] <= ram_req_i.wdata;
      end else begin
        rdata_q <= mem_q[ram_req_i.addr];
      end
    end
  end

  assign rdata_o       = rdata_q;
  assign rdata_valid_o = rdata_valid_q;

endmodule

// ==== hdl/sw_status_monitor.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Snoops RAM writes to the software test-status
// and log words
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

`include "chip_settings.svh"

module sw_status_monitor (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               ram_valid_i,
  input  chip_pkg::mem_req_t ram_req_i,
  output logic               status_valid_o,
  output logic [31:0]        status_o,
  output logic               log_valid_o,
  output logic [31:0]        log_o
);

  logic status_hit;
  logic log_hit;
  logic status_valid_q;
  logic log_valid_q;

  assign status_hit = ram_valid_i && ram_req_i.write && (ram_req_i.addr == `STATUS_ADDR);
  assign log_hit    = ram_valid_i && ram_req_i.write && (ram_req_i.addr == `LOG_ADDR);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      status_valid_q <= 1'b0;
      log_valid_q    <= 1'b0;
    end else begin
      status_valid_q <= status_hit;
      log_valid_q    <= log_hit;
    end
  end

  // Words hold until the next matching write
  always_ff @(posedge clk_i) begin
    if (status_hit) begin
      status_o <= ram_req_i.wdata;
    end
    if (log_hit) begin
      log_o <= ram_req_i.wdata;
    end
  end

  assign status_valid_o = status_valid_q;
  assign log_valid_o    = log_valid_q;

endmodule

// ==== hdl/chip_top.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Chip top: SPI and UART loaders sharing main
// RAM, plus the software status monitor
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module chip_top (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        spi_sck_i,
  input  logic        spi_csb_i,
  input  logic        spi_mosi_i,
  output logic        spi_miso_o,
  input  logic        uart_rx_i,
  output logic        status_valid_o,
  output logic [31:0] status_o,
  output logic        log_valid_o,
  output logic [31:0] log_o
);

  // Port 0 is SPI, port 1 is UART
  logic [1:0]               req;
  logic [1:0]               gnt;
  chip_pkg::mem_req_t [1:0] mem_req;
  logic                     ram_valid;
  chip_pkg::mem_req_t       ram_req;
  logic [31:0]              rdata;
  logic                     rdata_valid;

  spi_loader i_spi_loader (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .sck_i         (spi_sck_i),
    .csb_i         (spi_csb_i),
    .mosi_i        (spi_mosi_i),
    .miso_o        (spi_miso_o),
    .req_o         (req[0]),
    .mem_req_o     (mem_req[0]),
    .gnt_i         (gnt[0]),
    .rdata_i       (rdata),
    .rdata_valid_i (rdata_valid)
  );

  uart_loader i_uart_loader (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .rx_i      (uart_rx_i),
    .req_o     (req[1]),
    .mem_req_o (mem_req[1]),
    .gnt_i     (gnt[1])
  );

  ram_arbiter i_ram_arbiter (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (req),
    .mem_req_i   (mem_req),
    .gnt_o       (gnt),
    .ram_valid_o (ram_valid),
    .ram_req_o   (ram_req)
  );

  main_ram i_main_ram (
    .clk_i         (clk_i),
    .ram_valid_i   (ram_valid),
    .ram_req_i     (ram_req),
    .rdata_o       (rdata),
    .rdata_valid_o (rdata_valid)
  );

  sw_status_monitor i_sw_status_monitor (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .ram_valid_i    (ram_valid),
    .ram_req_i      (ram_req),
    .status_valid_o (status_valid_o),
    .status_o       (status_o),
    .log_valid_o    (log_valid_o),
    .log_o          (log_o)
  );

endmodule

// ==== test/tb_clk_gen.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock, 10 ns period, and reset held
// low for the first 3 cycles
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // Release 1 ns after an edge
  initial begin
    rst_n_o = 1'b0;
    repeat (3) @(posedge clk_o);
    #1;
    rst_n_o = 1'b1;
  end

endmodule

// ==== test/tb.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Chip loader testbench: SPI and UART drivers,
// status and log assertions, watchdog, counts
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

`include "chip_settings.svh"

module tb;

  localparam int SpiHalfClks   = 5;
  localparam int SpiFrameClks  = 3 + 56 * 2 * SpiHalfClks + 3 * SpiHalfClks;
  localparam int UartFrameClks = 1 + 6 * 10 * `UART_CLKS_PER_BIT + 20;
  localparam int NumSpiFrames  = 24;
  localparam int NumUartFrames = 2;
  localparam int NumWords      = 6;
  // SPI start delay so its last rising sck lines up with the last UART stop bit
  localparam int SpiLateStart  = 395;
  localparam int WatchdogNs    =
    2 * 10 * (NumSpiFrames * SpiFrameClks + NumUartFrames * UartFrameClks + 200);

  logic               clk;
  logic               rst_n;
  logic               spi_sck;
  logic               spi_csb;
  logic               spi_mosi;
  logic               spi_miso;
  logic               uart_rx;
  logic               status_valid;
  logic [31:0]        status;
  logic               log_valid;
  logic [31:0]        log_word;
  int                 seed = 42675;
  int                 error_count = 0;
  int                 check_count = 0;
  int                 status_pulses = 0;
  int                 log_pulses = 0;
  logic               status_armed;
  logic               log_armed;
  logic [31:0]        exp_status;
  logic [31:0]        exp_log;
  logic [`RAM_AW-1:0] addrs [NumWords];
  logic [31:0]        words [NumWords];

  tb_clk_gen i_tb_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  chip_top i_chip_top (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .spi_sck_i      (spi_sck),
    .spi_csb_i      (spi_csb),
    .spi_mosi_i     (spi_mosi),
    .spi_miso_o     (spi_miso),
    .uart_rx_i      (uart_rx),
    .status_valid_o (status_valid),
    .status_o       (status),
    .log_valid_o    (log_valid),
    .log_o          (log_word)
  );

  task automatic report_error(input string msg);
    error_count++;
    $display("Error at %0t: %s", $time, msg);
  endtask

  // Pulses only while a write to that word is expected, with its value
  status_pulse_ok: assert property (@(posedge clk) disable iff (!rst_n)
      status_valid |-> (status_armed && status == exp_status))
    else report_error("unexpected status pulse or wrong status value");
  status_pulse_single: assert property (@(posedge clk) disable iff (!rst_n)
      status_valid |=> !status_valid)
    else report_error("status pulse longer than one cycle");
  log_pulse_ok: assert property (@(posedge clk) disable iff (!rst_n)
      log_valid |-> (log_armed && log_word == exp_log))
    else report_error("unexpected log pulse or wrong log value");
  log_pulse_single: assert property (@(posedge clk) disable iff (!rst_n)
      log_valid |=> !log_valid)
    else report_error("log pulse longer than one cycle");

  always @(posedge clk) begin
    if (status_valid) begin
      status_pulses++;
    end
    if (log_valid) begin
      log_pulses++;
    end
  end

  task automatic wait_clks(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  function automatic logic [`RAM_AW-1:0] rand_addr(input int base);
    logic [31:0] r;
    r = base + ({$random(seed)} % 100);
    return r[`RAM_AW-1:0];
  endfunction

  // MSB first, mosi set on the falling edge, miso taken before the rising one
  task automatic spi_frame(input logic [7:0] op, input logic [15:0] addr,
                           input logic [31:0] wdata, input int nbits,
                           output logic [31:0] rdata);
    logic [55:0] frame;
    int          i;
    frame = {op, addr, wdata};
    rdata = '0;
    wait_clks(1);
    spi_csb = 1'b0;
    wait_clks(2);
    for (i = 0; i < nbits; i++) begin
      spi_sck  = 1'b0;
      spi_mosi = frame[55 - i];
      wait_clks(SpiHalfClks);
      if (i >= 24) begin
        rdata = {rdata[30:0], spi_miso};
      end
      spi_sck = 1'b1;
      wait_clks(SpiHalfClks);
    end
    spi_sck = 1'b0;
    wait_clks(SpiHalfClks);
    spi_csb = 1'b1;
    wait_clks(2 * SpiHalfClks);
  endtask

  task automatic spi_write(input logic [`RAM_AW-1:0] addr, input logic [31:0] data);
    logic [31:0] discard;
    spi_frame(`OP_WRITE, 16'(addr), data, 56, discard);
  endtask

  task automatic check_read(input logic [`RAM_AW-1:0] addr, input logic [31:0] exp);
    logic [31:0] got;
    spi_frame(`OP_READ, 16'(addr), 32'h0, 56, got);
    check_count++;
    assert (got == exp) else
      report_error($sformatf("read of 0x%03h gave 0x%08h, expected 0x%08h", addr, got, exp));
  endtask

  task automatic uart_byte(input logic [7:0] data);
    int i;
    uart_rx = 1'b0;
    wait_clks(`UART_CLKS_PER_BIT);
    for (i = 0; i < 8; i++) begin
      uart_rx = data[i];
      wait_clks(`UART_CLKS_PER_BIT);
    end
    uart_rx = 1'b1;
    wait_clks(`UART_CLKS_PER_BIT);
  endtask

  task automatic uart_frame(input logic [15:0] addr, input logic [31:0] data);
    logic [47:0] frame;
    int          i;
    frame = {addr, data};
    wait_clks(1);
    for (i = 0; i < 6; i++) begin
      uart_byte(frame[47 - 8 * i -: 8]);
    end
    wait_clks(20);
  endtask

  // Waits for the pulse totals, then a few quiet cycles for extras
  task automatic expect_pulses(input int status_n, input int log_n);
    int waited;
    waited = 0;
    while ((status_pulses != status_n || log_pulses != log_n) && waited < 20) begin
      wait_clks(1);
      waited++;
    end
    wait_clks(4);
    check_count++;
    assert (status_pulses == status_n && log_pulses == log_n) else
      report_error($sformatf("saw %0d status and %0d log pulses, expected %0d and %0d",
                             status_pulses, log_pulses, status_n, log_n));
  endtask

  initial begin
    #(WatchdogNs);
    $display("Watchdog timeout after %0d ns, the run did not complete", WatchdogNs);
    $display("Finished with errors");
    $finish;
  end

  initial begin
    logic [`RAM_AW-1:0] addr_a;
    logic [`RAM_AW-1:0] addr_b;
    logic [31:0]        word_a;
    logic [31:0]        word_b;
    logic [31:0]        discard;
    int                 i;
    spi_sck      = 1'b0;
    spi_csb      = 1'b1;
    spi_mosi     = 1'b0;
    uart_rx      = 1'b1;
    status_armed = 1'b0;
    log_armed    = 1'b0;
    exp_status   = '0;
    exp_log      = '0;
    @(posedge rst_n);
    wait_clks(2);

    // SPI writes, then read all back
    for (i = 0; i < NumWords; i++) begin
      addrs[i] = rand_addr(i * 100);
      words[i] = $random(seed);
      spi_write(addrs[i], words[i]);
    end
    for (i = 0; i < NumWords; i++) begin
      check_read(addrs[i], words[i]);
    end

    // UART write seen through SPI
    addr_a = rand_addr(600);
    word_a = $random(seed);
    uart_frame(16'(addr_a), word_a);
    check_read(addr_a, word_a);

    // Status word, then an ordinary write with no pulse
    exp_status   = chip_pkg::StatusPassed;
    status_armed = 1'b1;
    spi_write(`STATUS_ADDR, chip_pkg::StatusPassed);
    expect_pulses(1, 0);
    status_armed = 1'b0;
    spi_write(rand_addr(900), $random(seed));
    expect_pulses(1, 0);

    // Log word leaves status quiet
    exp_log   = $random(seed);
    log_armed = 1'b1;
    spi_write(`LOG_ADDR, exp_log);
    expect_pulses(1, 1);
    log_armed = 1'b0;

    // Both loaders request together
    addr_a = rand_addr(700);
    addr_b = rand_addr(800);
    word_a = $random(seed);
    word_b = $random(seed);
    fork
      uart_frame(16'(addr_a), word_a);
      begin
        wait_clks(SpiLateStart);
        spi_write(addr_b, word_b);
      end
    join
    check_read(addr_a, word_a);
    check_read(addr_b, word_b);

    // Cut-short write frame is dropped
    addr_a = rand_addr(600);
    word_a = $random(seed);
    spi_write(addr_a, word_a);
    spi_frame(`OP_WRITE, 16'(addr_a), ~word_a, 40, discard);
    check_read(addr_a, word_a);
    expect_pulses(1, 1);

    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+hdl
hdl/chip_pkg.sv
hdl/spi_loader.sv
hdl/uart_loader.sv
hdl/ram_arbiter.sv
hdl/main_ram.sv
hdl/sw_status_monitor.sv
hdl/chip_top.sv
test/tb_clk_gen.sv
test/tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps -j 0
FAIL_MSG  ?= Finished with errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   show this list"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	fi; \
	exit $$status

clean:
	rm -rf $(BUILD_DIR) $(LOG)
